/* source/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_OP     = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_INOUT  = 7'b1111111   // custom uart access
    } opcode_t;

    localparam funct3_t F3_ADDI    = 3'b000;
    localparam funct3_t F3_SLLI    = 3'b001;
    localparam funct3_t F3_XORI    = 3'b100;
    localparam funct3_t F3_SRAI    = 3'b101;
    localparam funct3_t F3_ANDI    = 3'b111;
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_JALR    = 3'b000;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;
    localparam funct3_t F3_BLT     = 3'b100;
    localparam funct3_t F3_BGE     = 3'b101;
    localparam funct3_t F3_LW      = 3'b010;
    localparam funct3_t F3_SW      = 3'b010;
    localparam funct3_t F3_OUT     = 3'b000;
    localparam funct3_t F3_IN      = 3'b001;

    localparam funct7_t F7_BASE    = 7'b0000000;
    localparam funct7_t F7_SUB     = 7'b0100000;
    localparam funct7_t F7_SRA     = 7'b0100000;

    localparam word_t UART_RX_ADDR   = 32'd0;
    localparam word_t UART_TX_ADDR   = 32'd4;
    localparam word_t UART_STAT_ADDR = 32'd8;

    localparam int STAT_RX_VALID_BIT = 0;
    localparam int STAT_TX_FULL_BIT  = 3;

endpackage

`default_nettype wire

/* source/core_bus_pkg.sv */
`default_nettype none

package core_bus_pkg;

    typedef logic [15:0] dmem_addr_t;   // word index
    typedef logic [14:0] imem_addr_t;   // word index
    typedef logic [1:0]  exec_len_t;

    typedef struct packed {
        logic                we;
        dmem_addr_t          addr;
        rv_isa_pkg::word_t   wdata;
    } dmem_req_t;

    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_m2s_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_s2m_t;

    typedef struct packed {
        rv_isa_pkg::opcode_t  opcode;
        rv_isa_pkg::funct3_t  funct3;
        rv_isa_pkg::funct7_t  funct7;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::word_t    imm_i;
        rv_isa_pkg::word_t    imm_s;
        rv_isa_pkg::word_t    imm_b;
        rv_isa_pkg::word_t    imm_u;
        rv_isa_pkg::word_t    shamt;
    } decoded_t;

endpackage

`default_nettype wire

/* source/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  rv_isa_pkg::word_t       instr,
    output core_bus_pkg::decoded_t  dec,
    output core_bus_pkg::exec_len_t exec_len
);

    always_comb begin
        dec.opcode = rv_isa_pkg::opcode_t'(instr[6:0]);
        dec.funct3 = instr[14:12];
        dec.funct7 = instr[31:25];
        dec.rd     = instr[11:7];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.imm_i  = {{20{instr[31]}}, instr[31:20]};
        dec.imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        dec.imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        dec.imm_u  = {instr[31:12], 12'b0};
        dec.shamt  = {27'b0, instr[24:20]};
    end

    always_comb begin
        case (dec.opcode)
            rv_isa_pkg::OP_LOAD:  exec_len = 2'd3;   // address, memory latency, sample
            rv_isa_pkg::OP_STORE: exec_len = 2'd2;
            default:              exec_len = 2'd1;   // io ends on io_done
        endcase
    end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int MEM_WORDS = 65536
) (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_isa_pkg::reg_idx_t rs1_idx,
    input  rv_isa_pkg::reg_idx_t rs2_idx,
    output rv_isa_pkg::word_t    rs1_val,
    output rv_isa_pkg::word_t    rs2_val,
    input  logic                 wr_en,
    input  rv_isa_pkg::reg_idx_t wr_idx,
    input  rv_isa_pkg::word_t    wr_data
);

    localparam rv_isa_pkg::word_t SP_INIT = rv_isa_pkg::word_t'(MEM_WORDS * 4);

    rv_isa_pkg::word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (!rst) begin
            regs[0] <= '0;
            regs[2] <= SP_INIT;   // stack starts at top of dmem
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rs1_val <= regs[rs1_idx];
        rs2_val <= regs[rs2_idx];
    end

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst)
        (rs1_idx == '0) |=> (rs1_val == '0));

endmodule

`default_nettype wire

/* source/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  core_bus_pkg::decoded_t dec,
    input  rv_isa_pkg::word_t      pc,
    input  rv_isa_pkg::word_t      rs1_val,
    input  rv_isa_pkg::word_t      rs2_val,
    output rv_isa_pkg::word_t      result,
    output rv_isa_pkg::word_t      next_pc
);

    rv_isa_pkg::word_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        logic taken;
        taken   = 1'b0;
        result  = '0;
        next_pc = pc_plus4;
        case (dec.opcode)
            rv_isa_pkg::OP_IMM: begin
                case (dec.funct3)
                    rv_isa_pkg::F3_ADDI: result = rs1_val + dec.imm_i;
                    rv_isa_pkg::F3_SLLI: result = rs1_val << dec.shamt[4:0];
                    rv_isa_pkg::F3_XORI: result = rs1_val ^ dec.imm_i;
                    rv_isa_pkg::F3_SRAI: result = $signed(rs1_val) >>> dec.shamt[4:0];
                    rv_isa_pkg::F3_ANDI: result = rs1_val & dec.imm_i;
                    default:             result = rs1_val;
                endcase
            end
            rv_isa_pkg::OP_OP: begin
                if (dec.funct3 == rv_isa_pkg::F3_XOR) begin
                    result = rs1_val ^ rs2_val;
                end else if (dec.funct7 == rv_isa_pkg::F7_SUB) begin
                    result = rs1_val - rs2_val;
                end else begin
                    result = rs1_val + rs2_val;
                end
            end
            rv_isa_pkg::OP_LUI:   result = dec.imm_u;
            rv_isa_pkg::OP_AUIPC: result = pc + dec.imm_u;
            rv_isa_pkg::OP_JALR: begin
                result  = pc_plus4;   // link
                next_pc = (rs1_val + dec.imm_i) & ~32'd1;
            end
            rv_isa_pkg::OP_BRANCH: begin
                case (dec.funct3)
                    rv_isa_pkg::F3_BEQ: taken = rs1_val == rs2_val;
                    rv_isa_pkg::F3_BNE: taken = rs1_val != rs2_val;
                    rv_isa_pkg::F3_BLT: taken = $signed(rs1_val) < $signed(rs2_val);
                    rv_isa_pkg::F3_BGE: taken = $signed(rs1_val) >= $signed(rs2_val);
                    default:            taken = 1'b0;
                endcase
                if (taken) next_pc = pc + dec.imm_b;
            end
            default: result = '0;   // loads, stores, io and unknown just step
        endcase
    end

endmodule

`default_nettype wire

/* source/uart_port.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_port (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    io_start,
    input  logic                    io_dir_out,
    input  logic [7:0]              tx_byte,
    output logic                    io_done,
    output logic [7:0]              rx_byte,
    output core_bus_pkg::axil_m2s_t axil_m,
    input  core_bus_pkg::axil_s2m_t axil_s
);

    typedef enum logic [3:0] {
        IDLE, STAT_REQ, STAT_WAIT, CHECK, TX_REQ, TX_RESP, RX_REQ, RX_WAIT, DONE
    } state_t;

    state_t            state;
    logic              dir_out;
    logic [7:0]        tx_hold;
    rv_isa_pkg::word_t stat;
    logic              aw_done;
    logic              w_done;

    assign io_done = state == DONE;
    assign aw_done = !axil_m.awvalid || axil_s.awready;
    assign w_done  = !axil_m.wvalid || axil_s.wready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state  <= IDLE;
            axil_m <= '0;
        end else begin
            case (state)
                IDLE: if (io_start) begin
                    axil_m.arvalid <= 1'b1;
                    axil_m.araddr  <= rv_isa_pkg::UART_STAT_ADDR;
                    state          <= STAT_REQ;
                end
                STAT_REQ: if (axil_s.arready) begin
                    axil_m.arvalid <= 1'b0;
                    axil_m.rready  <= 1'b1;
                    state          <= STAT_WAIT;
                end
                STAT_WAIT: if (axil_s.rvalid) begin
                    axil_m.rready <= 1'b0;
                    state         <= CHECK;
                end
                CHECK: begin
                    if (dir_out && !stat[rv_isa_pkg::STAT_TX_FULL_BIT]) begin
                        axil_m.awvalid <= 1'b1;
                        axil_m.awaddr  <= rv_isa_pkg::UART_TX_ADDR;
                        axil_m.wvalid  <= 1'b1;
                        axil_m.wdata   <= {24'b0, tx_hold};
                        axil_m.wstrb   <= 4'b0001;
                        state          <= TX_REQ;
                    end else if (!dir_out && stat[rv_isa_pkg::STAT_RX_VALID_BIT]) begin
                        axil_m.arvalid <= 1'b1;
                        axil_m.araddr  <= rv_isa_pkg::UART_RX_ADDR;
                        state          <= RX_REQ;
                    end else begin
                        axil_m.arvalid <= 1'b1;   // poll again
                        axil_m.araddr  <= rv_isa_pkg::UART_STAT_ADDR;
                        state          <= STAT_REQ;
                    end
                end
                TX_REQ: begin
                    if (axil_s.awready) axil_m.awvalid <= 1'b0;
                    if (axil_s.wready) axil_m.wvalid <= 1'b0;
                    if (aw_done && w_done) begin
                        axil_m.bready <= 1'b1;
                        state         <= TX_RESP;
                    end
                end
                TX_RESP: if (axil_s.bvalid) begin
                    axil_m.bready <= 1'b0;
                    state         <= DONE;
                end
                RX_REQ: if (axil_s.arready) begin
                    axil_m.arvalid <= 1'b0;
                    axil_m.rready  <= 1'b1;
                    state          <= RX_WAIT;
                end
                RX_WAIT: if (axil_s.rvalid) begin
                    axil_m.rready <= 1'b0;
                    state         <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && io_start) begin
            dir_out <= io_dir_out;
            tx_hold <= tx_byte;
        end
        if (state == STAT_WAIT && axil_s.rvalid) stat <= axil_s.rdata;
        if (state == RX_WAIT && axil_s.rvalid) rx_byte <= axil_s.rdata[7:0];
    end

    a_arvalid_hold: assert property (@(posedge clk) disable iff (!rst)
        (axil_m.arvalid && !axil_s.arready) |=> axil_m.arvalid);

endmodule

`default_nettype wire

/* source/core_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module core_ctrl #(
    parameter int MEM_WORDS = 65536
) (
    input  logic                     clk,
    input  logic                     rst,
    input  core_bus_pkg::decoded_t   dec,
    input  core_bus_pkg::exec_len_t  exec_len,
    input  rv_isa_pkg::word_t        rs1_val,
    input  rv_isa_pkg::word_t        rs2_val,
    input  rv_isa_pkg::word_t        alu_result,
    input  rv_isa_pkg::word_t        alu_next_pc,
    input  rv_isa_pkg::word_t        dmem_rdata,
    output core_bus_pkg::imem_addr_t imem_addr,
    output core_bus_pkg::dmem_req_t  dmem_req,
    output rv_isa_pkg::word_t        pc,
    output logic                     rf_wr_en,
    output rv_isa_pkg::reg_idx_t     rf_wr_idx,
    output rv_isa_pkg::word_t        rf_wr_data,
    output logic                     io_start,
    output logic                     io_dir_out,
    output logic [7:0]               tx_byte,
    input  logic                     io_done,
    input  logic [7:0]               rx_byte,
    output logic                     halted
);

    typedef enum logic [2:0] {FETCH, READ, EXEC, WB, HALT} state_t;

    state_t                  state;
    core_bus_pkg::exec_len_t cnt;
    rv_isa_pkg::word_t       wb_data;
    rv_isa_pkg::word_t       mem_addr;
    logic                    is_load;
    logic                    is_store;
    logic                    is_io;
    logic                    has_rd;
    logic                    last_exec;

    assign is_load  = dec.opcode == rv_isa_pkg::OP_LOAD;
    assign is_store = dec.opcode == rv_isa_pkg::OP_STORE;
    assign is_io    = dec.opcode == rv_isa_pkg::OP_INOUT;
    assign mem_addr = rs1_val + (is_store ? dec.imm_s : dec.imm_i);

    always_comb begin
        case (dec.opcode)
            rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_OP, rv_isa_pkg::OP_LUI,
            rv_isa_pkg::OP_AUIPC, rv_isa_pkg::OP_JALR, rv_isa_pkg::OP_LOAD: has_rd = 1'b1;
            rv_isa_pkg::OP_INOUT: has_rd = dec.funct3 != rv_isa_pkg::F3_OUT;   // "in" only
            default:              has_rd = 1'b0;
        endcase
    end

    assign last_exec = is_io ? io_done : (cnt == core_bus_pkg::exec_len_t'(exec_len - 2'd1));

    assign imem_addr      = pc[16:2];
    assign dmem_req.we    = state == EXEC && is_store && cnt == '0;
    assign dmem_req.addr  = mem_addr[17:2];
    assign dmem_req.wdata = rs2_val;

    assign io_start   = state == EXEC && is_io && cnt == '0;
    assign io_dir_out = dec.funct3 == rv_isa_pkg::F3_OUT;
    assign tx_byte    = rs1_val[7:0];

    assign rf_wr_en   = state == WB && has_rd;
    assign rf_wr_idx  = dec.rd;
    assign rf_wr_data = wb_data;
    assign halted     = state == HALT;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= FETCH;
            pc    <= '0;
            cnt   <= '0;
        end else begin
            case (state)
                FETCH: state <= READ;   // rom word valid next cycle
                READ: begin
                    cnt   <= '0;
                    state <= EXEC;
                end
                EXEC: begin
                    if (last_exec) begin
                        state <= WB;
                    end else if (!is_io || cnt == '0) begin
                        cnt <= cnt + 2'd1;   // io parks at 1 until done
                    end
                end
                WB: begin
                    pc    <= alu_next_pc;
                    state <= (alu_next_pc == pc) ? HALT : FETCH;
                end
                default: state <= HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXEC && last_exec) begin
            if (is_load) begin
                wb_data <= dmem_rdata;   // third exec cycle
            end else if (is_io) begin
                wb_data <= {24'b0, rx_byte};
            end else begin
                wb_data <= alu_result;
            end
        end
    end

    a_we_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        dmem_req.we |=> !dmem_req.we);

    a_dmem_in_range: assert property (@(posedge clk) disable iff (!rst)
        (state == EXEC && (is_load || is_store)) |-> (mem_addr[31:2] < MEM_WORDS));

endmodule

`default_nettype wire

/* source/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int MEM_WORDS = 65536
) (
    input  logic                     clk,
    input  logic                     rst,
    output core_bus_pkg::imem_addr_t imem_addr,
    input  rv_isa_pkg::word_t        imem_data,
    output core_bus_pkg::dmem_req_t  dmem_req,
    input  rv_isa_pkg::word_t        dmem_rdata,
    output core_bus_pkg::axil_m2s_t  axil_m,
    input  core_bus_pkg::axil_s2m_t  axil_s,
    output logic                     halted
);

    core_bus_pkg::decoded_t  dec;
    core_bus_pkg::exec_len_t exec_len;
    rv_isa_pkg::word_t       rs1_val;
    rv_isa_pkg::word_t       rs2_val;
    rv_isa_pkg::word_t       alu_result;
    rv_isa_pkg::word_t       alu_next_pc;
    rv_isa_pkg::word_t       pc;
    logic                    rf_wr_en;
    rv_isa_pkg::reg_idx_t    rf_wr_idx;
    rv_isa_pkg::word_t       rf_wr_data;
    logic                    io_start;
    logic                    io_dir_out;
    logic [7:0]              tx_byte;
    logic                    io_done;
    logic [7:0]              rx_byte;

    instr_decode u_decode (.instr(imem_data), .dec(dec), .exec_len(exec_len));

    reg_file #(.MEM_WORDS(MEM_WORDS)) u_regs (
        .clk(clk), .rst(rst), .rs1_idx(dec.rs1), .rs2_idx(dec.rs2),
        .rs1_val(rs1_val), .rs2_val(rs2_val),
        .wr_en(rf_wr_en), .wr_idx(rf_wr_idx), .wr_data(rf_wr_data)
    );

    int_alu u_alu (
        .dec(dec), .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .result(alu_result), .next_pc(alu_next_pc)
    );

    core_ctrl #(.MEM_WORDS(MEM_WORDS)) u_ctrl (
        .clk(clk), .rst(rst), .dec(dec), .exec_len(exec_len),
        .rs1_val(rs1_val), .rs2_val(rs2_val),
        .alu_result(alu_result), .alu_next_pc(alu_next_pc), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_req(dmem_req), .pc(pc),
        .rf_wr_en(rf_wr_en), .rf_wr_idx(rf_wr_idx), .rf_wr_data(rf_wr_data),
        .io_start(io_start), .io_dir_out(io_dir_out), .tx_byte(tx_byte),
        .io_done(io_done), .rx_byte(rx_byte), .halted(halted)
    );

    uart_port u_uart (
        .clk(clk), .rst(rst), .io_start(io_start), .io_dir_out(io_dir_out),
        .tx_byte(tx_byte), .io_done(io_done), .rx_byte(rx_byte),
        .axil_m(axil_m), .axil_s(axil_s)
    );

endmodule

`default_nettype wire

/* dv/tb_models.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_models (
    input  logic                     clk,
    input  core_bus_pkg::imem_addr_t imem_addr,
    output rv_isa_pkg::word_t        imem_data,
    input  core_bus_pkg::dmem_req_t  dmem_req,
    output rv_isa_pkg::word_t        dmem_rdata,
    input  core_bus_pkg::axil_m2s_t  axil_m,
    output core_bus_pkg::axil_s2m_t  axil_s
);

    rv_isa_pkg::word_t rom  [0:1023];
    rv_isa_pkg::word_t dmem [0:63];

    logic [7:0]  tx_log [$];   // every byte written to the tx register
    logic [7:0]  rx_q   [$];
    bit          bp;           // random back-pressure on
    int          rx_wait;
    int          addr_errs;    // accesses outside the uart register map
    bit          tx_full;
    bit          aw_got;
    bit          w_got;
    logic        ar_hs;
    logic        r_hs;
    logic        aw_hs;
    logic        w_hs;
    logic        b_hs;
    logic [31:0] ar_addr;
    logic [31:0] aw_addr;
    logic [31:0] w_data;
    logic [3:0]  w_strb;

    initial begin
        imem_data  = '0;
        dmem_rdata = '0;
        axil_s     = '0;
        bp         = 1'b0;
        rx_wait    = 0;
        addr_errs  = 0;
        tx_full    = 1'b0;
        aw_got     = 1'b0;
        w_got      = 1'b0;
    end

    task automatic clear_uart();
        tx_log.delete();
        rx_q.delete();
        axil_s    = '0;
        aw_got    = 1'b0;
        w_got     = 1'b0;
        addr_errs = 0;
        rx_wait   = $urandom % 8;
    endtask

    function automatic bit ready_roll();
        return !bp || ($urandom % 3 == 0);
    endfunction

    // handshakes seen at the rising edge
    always @(posedge clk) begin
        ar_hs <= axil_m.arvalid && axil_s.arready;
        r_hs  <= axil_s.rvalid && axil_m.rready;
        aw_hs <= axil_m.awvalid && axil_s.awready;
        w_hs  <= axil_m.wvalid && axil_s.wready;
        b_hs  <= axil_s.bvalid && axil_m.bready;
        if (axil_m.arvalid && axil_s.arready) ar_addr <= axil_m.araddr;
        if (axil_m.awvalid && axil_s.awready) aw_addr <= axil_m.awaddr;
        if (axil_m.wvalid && axil_s.wready) begin
            w_data <= axil_m.wdata;
            w_strb <= axil_m.wstrb;
        end
    end

    always @(negedge clk) begin
        imem_data = rom[imem_addr[9:0]];
        if (dmem_req.we) dmem[dmem_req.addr[5:0]] = dmem_req.wdata;
        dmem_rdata = dmem[dmem_req.addr[5:0]];
        if (rx_wait > 0) rx_wait--;
        tx_full = bp && ($urandom % 2 == 0);

        if (r_hs) axil_s.rvalid = 1'b0;
        if (ar_hs) begin
            axil_s.rvalid = 1'b1;
            if (ar_addr != 32'd0 && ar_addr != 32'd8) addr_errs++;
            if (ar_addr == 32'd0 && rx_q.size() > 0) begin
                axil_s.rdata = {24'b0, rx_q.pop_front()};
                rx_wait      = $urandom % 8;   // next byte shows up later
            end else begin
                axil_s.rdata = {28'b0, tx_full, 2'b0, rx_q.size() > 0 && rx_wait == 0};
            end
        end
        axil_s.arready = axil_m.arvalid && !axil_s.rvalid && ready_roll();

        if (b_hs) axil_s.bvalid = 1'b0;
        if (aw_hs) aw_got = 1'b1;
        if (w_hs) begin
            w_got = 1'b1;
            tx_log.push_back(w_data[7:0]);
        end
        axil_s.awready = axil_m.awvalid && ready_roll();
        axil_s.wready  = axil_m.wvalid && ready_roll();
        if (aw_got && w_got) begin
            if (aw_addr != 32'd4 || w_strb != 4'b0001) addr_errs++;
            axil_s.bvalid = 1'b1;
            aw_got        = 1'b0;
            w_got         = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    logic                     clk;
    logic                     rst;
    core_bus_pkg::imem_addr_t imem_addr;
    rv_isa_pkg::word_t        imem_data;
    core_bus_pkg::dmem_req_t  dmem_req;
    rv_isa_pkg::word_t        dmem_rdata;
    core_bus_pkg::axil_m2s_t  axil_m;
    core_bus_pkg::axil_s2m_t  axil_s;
    logic                     halted;

    rv_isa_pkg::word_t prog   [$];
    logic [7:0]        exp_q  [$];
    logic [7:0]        rx_in  [$];
    bit                bp_mode;

    cpu_top #(.MEM_WORDS(64)) dut0 (
        .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata),
        .axil_m(axil_m), .axil_s(axil_s), .halted(halted)
    );

    tb_models mdl (
        .clk(clk), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .axil_m(axil_m), .axil_s(axil_s)
    );

    always #20 clk = ~clk;

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            fail_stop("check failed");
        end
    endtask

    function automatic logic [31:0] i_type(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] s_type(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic addi(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
        emit(i_type(7'h13, 3'b000, rd, rs1, imm[11:0]));
    endtask

    task automatic out_expect(input logic [4:0] rs1, input int val);
        emit({12'b0, rs1, 3'b000, 5'b0, 7'h7f});
        exp_q.push_back(val[7:0]);
    endtask

    task automatic new_program();
        prog.delete();
        exp_q.delete();
        rx_in.delete();
        bp_mode = 1'b0;
    endtask

    // program ends in beq x0,x0,0 then runs from reset
    task automatic run_program();
        int cyc;
        emit(b_type(3'b000, 5'd0, 5'd0, 13'd0));
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 1024; i++) mdl.rom[i] = {i[24:0], 7'b0};   // opcode 0 steps
        foreach (prog[i]) mdl.rom[i] = prog[i];
        for (int i = 0; i < 64; i++) mdl.dmem[i] = {16'hc0de, 10'b0, i[5:0]};
        mdl.clear_uart();
        mdl.bp = bp_mode;
        foreach (rx_in[i]) mdl.rx_q.push_back(rx_in[i]);
        repeat (5) @(negedge clk);
        rst = 1'b1;
        for (cyc = 0; cyc < 20000 && !halted; cyc++) @(negedge clk);
        if (!halted) fail_stop("timeout: core never reached halted");
        check("uart_addr_errs", mdl.addr_errs, 0);
        check("tx_count", mdl.tx_log.size(), exp_q.size());
        foreach (exp_q[i]) check("tx_byte", mdl.tx_log[i], exp_q[i]);
    endtask

    task automatic arith_results();
        int a;
        int pc;
        a = -100;
        new_program();
        addi(1, 0, a);
        out_expect(1, a);
        emit(i_type(7'h13, 3'b001, 3, 1, 12'd3));
        out_expect(3, a << 3);
        emit(i_type(7'h13, 3'b100, 4, 1, 12'h055));
        out_expect(4, a ^ 32'h55);
        emit(i_type(7'h13, 3'b101, 5, 1, 12'h41c));   // srai by 28
        out_expect(5, a >>> 28);
        emit(i_type(7'h13, 3'b111, 6, 1, 12'h07f));
        out_expect(6, a & 32'h7f);
        emit(r_type(7'h00, 3'b000, 7, 1, 3));
        out_expect(7, a + (a << 3));
        emit(r_type(7'h20, 3'b000, 8, 3, 1));
        out_expect(8, (a << 3) - a);
        emit(r_type(7'h00, 3'b100, 9, 4, 6));
        out_expect(9, (a ^ 32'h55) ^ (a & 32'h7f));
        emit(u_type(7'h37, 10, 20'h12345));
        emit(i_type(7'h13, 3'b101, 10, 10, 12'h40c));
        out_expect(10, 32'h12345);
        pc = prog.size() * 4;
        emit(u_type(7'h17, 11, 20'h00001));
        out_expect(11, pc + 32'h1000);
        emit(i_type(7'h13, 3'b101, 12, 11, 12'h408));   // upper bits of the auipc sum
        out_expect(12, (pc + 32'h1000) >>> 8);
        run_program();
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic [4:0] ra, input logic [4:0] rb,
                               input int va, input int vb, input int mark);
        bit taken;
        case (f3)
            3'b000:  taken = va == vb;
            3'b001:  taken = va != vb;
            3'b100:  taken = va < vb;
            default: taken = va >= vb;
        endcase
        emit(b_type(f3, ra, rb, 13'd12));
        addi(20, 0, mark);
        emit({12'b0, 5'd20, 3'b000, 5'b0, 7'h7f});
        if (!taken) exp_q.push_back(mark[7:0]);
        addi(20, 0, mark + 1);
        out_expect(20, mark + 1);
    endtask

    task automatic branch_paths();
        int k;
        new_program();
        addi(1, 0, -5);
        addi(3, 0, 3);
        branch_case(3'b000, 1, 1, -5, -5, 8'h10);
        branch_case(3'b000, 1, 3, -5, 3, 8'h20);
        branch_case(3'b001, 1, 3, -5, 3, 8'h30);
        branch_case(3'b001, 3, 3, 3, 3, 8'h40);
        branch_case(3'b100, 1, 3, -5, 3, 8'h50);   // signed compare
        branch_case(3'b100, 3, 1, 3, -5, 8'h60);
        branch_case(3'b101, 3, 1, 3, -5, 8'h70);
        branch_case(3'b101, 1, 3, -5, 3, 8'h80);
        k = prog.size();
        emit(i_type(7'h67, 3'b000, 5, 0, 12'((k + 3) * 4)));
        addi(20, 0, 8'hee);
        emit({12'b0, 5'd20, 3'b000, 5'b0, 7'h7f});   // skipped by the jump
        out_expect(5, (k + 1) * 4);
        run_program();
    endtask

    task automatic load_store();
        int          offs [3];
        logic [31:0] vals [3];
        offs = '{0, 20, 252};
        vals = '{32'habcde123, 32'h13579246, 32'h8000077f};
        new_program();
        for (int i = 0; i < 3; i++) begin
            emit(u_type(7'h37, 6, vals[i][31:12]));
            addi(6, 6, vals[i][11:0]);
            emit(s_type(0, 6, 12'(offs[i])));
            emit(i_type(7'h03, 3'b010, 7, 0, 12'(offs[i])));
            out_expect(7, vals[i]);
        end
        addi(0, 0, 55);
        out_expect(0, 0);
        emit(i_type(7'h13, 3'b101, 8, 2, 12'h402));
        out_expect(8, 64);
        run_program();
        for (int i = 0; i < 3; i++) check("dmem_word", mdl.dmem[offs[i] / 4], vals[i]);
    endtask

    task automatic uart_input();
        logic [7:0] b;
        new_program();
        for (int i = 0; i < 6; i++) begin
            b = (i == 5) ? 8'hff : 8'($urandom);
            rx_in.push_back(b);
            emit({12'b0, 5'd0, 3'b001, 5'd5, 7'h7f});
            addi(5, 5, 1);
            out_expect(5, b + 1);   // wraps at 256
        end
        run_program();
    endtask

    task automatic tx_backpressure();
        int v;
        new_program();
        bp_mode = 1'b1;
        for (int i = 0; i < 12; i++) begin
            v = $urandom % 256;
            addi(5, 0, v);
            out_expect(5, v);
        end
        run_program();
    endtask

    task automatic halt_hold();
        core_bus_pkg::imem_addr_t addr;
        addr = imem_addr;
        repeat (50) begin
            @(negedge clk);
            check("halted", halted, 1);
            check("imem_addr", imem_addr, addr);
            check("axil_valids", {axil_m.arvalid, axil_m.awvalid, axil_m.wvalid}, 0);
        end
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b0;
        bp_mode = 1'b0;
        void'($urandom(32'hfde9c330));
        arith_results();
        branch_paths();
        load_store();
        uart_input();
        tx_backpressure();
        halt_hold();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/rv_isa_pkg.sv
source/core_bus_pkg.sv
source/instr_decode.sv
source/reg_file.sv
source/int_alu.sv
source/uart_port.sv
source/core_ctrl.sv
source/cpu_top.sv
dv/tb_models.sv
dv/cpu_tb.sv
